//--- rtl/infra_pkg.sv
package infra_pkg;

  // Staged reset domains, released low bit first
  // bit 0 sys_clk, bit 1 sys_clk90, bit 2 sys_clk2x, bit 3 aux
  localparam int NUM_DOMAINS = 4;

  // Sequencing intervals in sys_clk cycles
  localparam int LOCK_STABLE_CYCLES = 16;  // Lock high before domain 0 release
  localparam int RST_STAGGER_CYCLES = 4;   // Gap between domain releases
  localparam int IDELAY_CAL_CYCLES  = 12;  // Calibration window

  localparam int TIMER_W    = 5;
  localparam int LOSS_CNT_W = 4;  // Saturates at all ones

  // Timer load values. Each interval above is counted from an output edge,
  // so the pipeline around the timer is taken off here.
  // Qualify covers the first stagger gap plus load and step latency
  localparam logic [TIMER_W-1:0] QUAL_LOAD =
    TIMER_W'(LOCK_STABLE_CYCLES - RST_STAGGER_CYCLES - 2);
  localparam logic [TIMER_W-1:0] STAGGER_LOAD =
    TIMER_W'(RST_STAGGER_CYCLES - 1);
  // Power-up calibration starts one cycle after the last release
  localparam logic [TIMER_W-1:0] CAL_LOAD =
    TIMER_W'(IDELAY_CAL_CYCLES - 2);
  // Recalibration load lands on the same edge as the idelay_rdy drop
  localparam logic [TIMER_W-1:0] RECAL_LOAD =
    TIMER_W'(IDELAY_CAL_CYCLES - 1);

  typedef enum logic [2:0] {
    WAIT_LOCK,
    QUALIFY,
    RELEASE,
    CALIBRATE,
    RUN
  } seq_state_t;

  // Raw asynchronous inputs, synchronized together
  typedef struct packed {
    logic mmcm_locked;
    logic idelay_rst;
  } async_ctrl_t;

  typedef struct packed {
    seq_state_t            state;
    logic [LOSS_CNT_W-1:0] lock_loss_count;
    logic                  cal_busy;
  } infra_status_t;

endpackage

//--- rtl/infra_sync.sv
`timescale 1ns/100ps

// Two-stage synchronizer for level signals into sys_clk
module infra_sync #(
  parameter type T = logic
) (
  input  logic sys_clk,
  input  logic rst_n,
  input  T     d,
  output T     q
);

  T meta;  // First stage, may go metastable

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      meta <= '0;
      q    <= '0;  // Lock reads as lost after reset
    end else begin
      meta <= d;
      q    <= meta;
    end
  end

endmodule

//--- rtl/infra_timer.sv
`timescale 1ns/100ps

module infra_timer
  import infra_pkg::*;
(
  input  logic               sys_clk,
  input  logic               rst_n,
  input  logic               load,
  input  logic [TIMER_W-1:0] value,
  output logic               done
);

  logic [TIMER_W-1:0] count;
  logic               busy;

  // Done is high exactly value cycles after the load edge
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        if (value == '0) begin
          // Degenerate interval, fire at once
          done <= 1'b1;
          busy <= 1'b0;
        end else begin
          count <= value - 1'b1;
          busy  <= 1'b1;  // Restarts a count in progress
        end
      end else if (busy) begin
        if (count == '0) begin
          done <= 1'b1;
          busy <= 1'b0;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/infra_domain_rst.sv
`timescale 1ns/100ps

// Thermometer stager for the per-domain resets
// Ones fill in from bit 0, so domains come out of reset in index order
module infra_domain_rst
  import infra_pkg::*;
(
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  logic                   step,
  input  logic                   clear,
  output logic [NUM_DOMAINS-1:0] domain_rst_n,
  output logic                   all_released
);

  logic [NUM_DOMAINS-1:0] therm;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      therm <= '0;  // Every domain in reset
    end else if (clear) begin
      therm <= '0;
    end else if (step) begin
      therm <= {therm[NUM_DOMAINS-2:0], 1'b1};
    end
  end

  // Bit n high means domain n is running
  assign domain_rst_n = therm;

  // Last domain out of reset
  assign all_released = therm[NUM_DOMAINS-1];

endmodule

//--- rtl/infra_reset_seq.sv
`timescale 1ns/100ps

module infra_reset_seq
  import infra_pkg::*;
(
  input  logic               sys_clk,
  input  logic               rst_n,
  input  logic               lock,
  input  logic               cal_req,
  input  logic               timer_done,
  input  logic               all_released,
  output logic               timer_load,
  output logic [TIMER_W-1:0] timer_value,
  output logic               stage_step,
  output logic               stage_clear,
  output logic               idelay_rdy,
  output logic               op_power_on_rst,
  output infra_status_t      status
);

  seq_state_t state;
  seq_state_t state_next;

  logic                  cal_req_q;
  logic                  cal_rise;
  logic                  cal_start;     // Recalibration request accepted
  logic                  recal_active;
  logic                  lock_lost;
  logic                  idelay_rdy_next;
  logic [LOSS_CNT_W-1:0] loss_cnt;

  assign cal_rise  = cal_req & ~cal_req_q;
  assign cal_start = cal_rise & (state == RUN);
  assign lock_lost = ~lock & (state != WAIT_LOCK);

  // Domains held in reset until lock is seen, dropped at once on loss
  assign stage_clear = ~lock | (state == WAIT_LOCK);

  always_comb begin
    state_next  = state;
    timer_load  = 1'b0;
    timer_value = '0;
    stage_step  = 1'b0;
    if (lock_lost) begin
      state_next = WAIT_LOCK;
    end else begin
      case (state)
        WAIT_LOCK: begin
          if (lock) begin
            state_next  = QUALIFY;
            timer_load  = 1'b1;
            timer_value = QUAL_LOAD;
          end
        end
        QUALIFY: begin
          if (timer_done) begin
            state_next  = RELEASE;
            timer_load  = 1'b1;
            timer_value = STAGGER_LOAD;
          end
        end
        RELEASE: begin
          if (all_released) begin
            state_next  = CALIBRATE;
            timer_load  = 1'b1;  // Cuts the stagger count short
            timer_value = CAL_LOAD;
          end else if (timer_done) begin
            stage_step  = 1'b1;
            timer_load  = 1'b1;
            timer_value = STAGGER_LOAD;
          end
        end
        CALIBRATE: begin
          if (timer_done) begin
            state_next = RUN;
          end
        end
        RUN: begin
          if (cal_start) begin
            timer_load  = 1'b1;
            timer_value = RECAL_LOAD;
          end
        end
        default: state_next = WAIT_LOCK;
      endcase
    end
  end

  // Ready only in RUN, and not while a recalibration window is open
  always_comb begin
    idelay_rdy_next = idelay_rdy;
    if (state_next != RUN) begin
      idelay_rdy_next = 1'b0;
    end else if (state == CALIBRATE) begin
      idelay_rdy_next = 1'b1;
    end else if (cal_start) begin
      idelay_rdy_next = 1'b0;
    end else if (recal_active && timer_done) begin
      idelay_rdy_next = 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= WAIT_LOCK;
      cal_req_q       <= 1'b0;
      recal_active    <= 1'b0;
      idelay_rdy      <= 1'b0;
      op_power_on_rst <= 1'b1;
      loss_cnt        <= '0;
    end else begin
      state           <= state_next;
      cal_req_q       <= cal_req;
      idelay_rdy      <= idelay_rdy_next;
      op_power_on_rst <= (state_next != RUN);

      if (state_next != RUN) begin
        recal_active <= 1'b0;
      end else if (cal_start) begin
        recal_active <= 1'b1;
      end else if (timer_done) begin
        recal_active <= 1'b0;
      end

      // A glitch during qualification is not a real loss
      if (lock_lost && state != QUALIFY && loss_cnt != '1) begin
        loss_cnt <= loss_cnt + 1'b1;
      end
    end
  end

  assign status = '{
    state:           state,
    lock_loss_count: loss_cnt,
    cal_busy:        (state == CALIBRATE) | recal_active
  };

endmodule

//--- rtl/roach_infrastructure.sv
`timescale 1ns/100ps

module roach_infrastructure
  import infra_pkg::*;
(
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  async_ctrl_t            ctrl_in,
  output logic                   sys_clk_lock,
  output logic                   op_power_on_rst,
  output logic                   idelay_rdy,
  output logic [NUM_DOMAINS-1:0] domain_rst_n,
  output infra_status_t          status
);

  async_ctrl_t        ctrl_sync;
  logic               timer_load;
  logic [TIMER_W-1:0] timer_value;
  logic               timer_done;
  logic               stage_step;
  logic               stage_clear;
  logic               all_released;

  // MMCM lock and recalibration request cross together
  infra_sync #(
    .T(async_ctrl_t)
  ) u_sync (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .d       (ctrl_in),
    .q       (ctrl_sync)
  );

  assign sys_clk_lock = ctrl_sync.mmcm_locked;

  infra_reset_seq u_seq (
    .sys_clk         (sys_clk),
    .rst_n           (rst_n),
    .lock            (ctrl_sync.mmcm_locked),
    .cal_req         (ctrl_sync.idelay_rst),
    .timer_done      (timer_done),
    .all_released    (all_released),
    .timer_load      (timer_load),
    .timer_value     (timer_value),
    .stage_step      (stage_step),
    .stage_clear     (stage_clear),
    .idelay_rdy      (idelay_rdy),
    .op_power_on_rst (op_power_on_rst),
    .status          (status)
  );

  infra_timer u_timer (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .load    (timer_load),
    .value   (timer_value),
    .done    (timer_done)
  );

  // Resets for sys_clk, sys_clk90, sys_clk2x and aux, in that order
  infra_domain_rst u_domain_rst (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .step         (stage_step),
    .clear        (stage_clear),
    .domain_rst_n (domain_rst_n),
    .all_released (all_released)
  );

endmodule

//--- sim/infra_assert.sv
`timescale 1ns/100ps

// Sequencer rules, bound into every infra_reset_seq
module infra_assert
  import infra_pkg::*;
(
  input logic       sys_clk,
  input logic       rst_n,
  input logic       lock,
  input logic       stage_step,
  input logic       idelay_rdy,
  input logic       op_power_on_rst,
  input seq_state_t state
);

  int fail_count = 0;  // Read by the testbench at the end of the run

  rdy_only_in_run: assert property (
    @(posedge sys_clk) disable iff (!rst_n) idelay_rdy |-> (state == RUN)
  ) else begin
    $error("idelay_rdy high in state %s", state.name());
    fail_count++;
  end

  // Power-on reset is the registered image of not-RUN
  por_tracks_run: assert property (
    @(posedge sys_clk) disable iff (!rst_n) op_power_on_rst == (state != RUN)
  ) else begin
    $error("op_power_on_rst %0b in state %s", op_power_on_rst, state.name());
    fail_count++;
  end

  step_only_in_release: assert property (
    @(posedge sys_clk) disable iff (!rst_n) stage_step |-> (state == RELEASE)
  ) else begin
    $error("stage_step pulsed in state %s", state.name());
    fail_count++;
  end

  lock_low_to_wait: assert property (
    @(posedge sys_clk) disable iff (!rst_n) !lock |=> (state == WAIT_LOCK)
  ) else begin
    $error("lock low but state moved to %s", state.name());
    fail_count++;
  end

endmodule

bind infra_reset_seq infra_assert u_assert (
  .sys_clk         (sys_clk),
  .rst_n           (rst_n),
  .lock            (lock),
  .stage_step      (stage_step),
  .idelay_rdy      (idelay_rdy),
  .op_power_on_rst (op_power_on_rst),
  .state           (state)
);

//--- sim/tb_roach_infrastructure.sv
`timescale 1ns/100ps

module tb_roach_infrastructure
  import infra_pkg::*;
();

  // One line of the stimulus file
  typedef struct packed {
    int                     test;
    logic                   lock;
    logic                   idelay;
    int                     hold;  // Cycles from the drive edge to the check
    logic                   exp_lock;
    logic [NUM_DOMAINS-1:0] exp_dom;
    logic                   exp_rdy;
    logic                   exp_por;
    logic [LOSS_CNT_W-1:0]  exp_cnt;
  } step_t;

  logic                   sys_clk;
  logic                   rst_n;
  async_ctrl_t            ctrl_in;
  logic                   sys_clk_lock;
  logic                   op_power_on_rst;
  logic                   idelay_rdy;
  logic [NUM_DOMAINS-1:0] domain_rst_n;
  infra_status_t          status;

  step_t steps[$];
  int    cycle_budget = 0;  // Sum of all holds
  int    cur_test;
  int    test_steps;
  int    test_errs;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    checks = 0;
  int    errors = 0;
  bit    file_ok = 1'b0;

  roach_infrastructure u_roach_infrastructure (
    .sys_clk         (sys_clk),
    .rst_n           (rst_n),
    .ctrl_in         (ctrl_in),
    .sys_clk_lock    (sys_clk_lock),
    .op_power_on_rst (op_power_on_rst),
    .idelay_rdy      (idelay_rdy),
    .domain_rst_n    (domain_rst_n),
    .status          (status)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;  // 20 ns period
  end

  task automatic load_steps();
    int    fd;
    int    n;
    int    bad_lines;
    string line;
    int    f_test, f_lock, f_idly, f_hold, f_elock, f_edom, f_erdy, f_epor, f_ecnt;
    step_t s;
    bad_lines = 0;
    fd = $fopen("sim/infra_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open sim/infra_stimulus.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%d %d %d %d %d %h %d %d %h", f_test, f_lock, f_idly, f_hold,
                  f_elock, f_edom, f_erdy, f_epor, f_ecnt);
      if (n != 9) begin
        if (n > 0) begin
          $display("Stimulus line could not be parsed: %s", line);
          bad_lines++;
        end
        continue;
      end
      // Zero hold means a glitch of random length, always under qualification
      if (f_hold == 0) f_hold = $urandom_range(LOCK_STABLE_CYCLES - 1, 4);
      s.test     = f_test;
      s.lock     = f_lock[0];
      s.idelay   = f_idly[0];
      s.hold     = f_hold;
      s.exp_lock = f_elock[0];
      s.exp_dom  = f_edom[NUM_DOMAINS-1:0];
      s.exp_rdy  = f_erdy[0];
      s.exp_por  = f_epor[0];
      s.exp_cnt  = f_ecnt[LOSS_CNT_W-1:0];
      steps.push_back(s);
      cycle_budget += f_hold;
    end
    $fclose(fd);
    file_ok = (steps.size() > 0) && (bad_lines == 0);
  endtask

  task automatic report_mismatch(input string what, input int exp_val, input int got_val);
    $display("ERR %0t: test %0d step %0d %s expected %0h got %0h",
             $time, cur_test, test_steps + 1, what, exp_val, got_val);
    errors++;
    test_errs++;
  endtask

  task automatic check_outputs(input step_t s);
    checks++;
    assert (sys_clk_lock === s.exp_lock) else
      report_mismatch("sys_clk_lock", int'(s.exp_lock), int'(sys_clk_lock));
    assert (domain_rst_n === s.exp_dom) else
      report_mismatch("domain_rst_n", int'(s.exp_dom), int'(domain_rst_n));
    assert (idelay_rdy === s.exp_rdy) else
      report_mismatch("idelay_rdy", int'(s.exp_rdy), int'(idelay_rdy));
    assert (op_power_on_rst === s.exp_por) else
      report_mismatch("op_power_on_rst", int'(s.exp_por), int'(op_power_on_rst));
    assert (status.lock_loss_count === s.exp_cnt) else
      report_mismatch("lock_loss_count", int'(s.exp_cnt), int'(status.lock_loss_count));
  endtask

  task automatic close_test();
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("Test %0d: %0d steps, %0d errors, %s", cur_test, test_steps, test_errs,
             (test_errs == 0) ? "ok" : "failed");
    test_steps = 0;
    test_errs  = 0;
  endtask

  task automatic run_steps();
    cur_test   = steps[0].test;
    test_steps = 0;
    test_errs  = 0;
    foreach (steps[i]) begin
      if (steps[i].test != cur_test) begin
        close_test();
        cur_test = steps[i].test;
      end
      @(posedge sys_clk);
      ctrl_in.mmcm_locked <= steps[i].lock;
      ctrl_in.idelay_rst  <= steps[i].idelay;
      repeat (steps[i].hold - 1) @(posedge sys_clk);
      @(negedge sys_clk);  // Last edge of the hold has settled
      check_outputs(steps[i]);
      test_steps++;
    end
    close_test();
  endtask

  initial begin
    int assert_fails;
    rst_n   <= 1'b0;
    ctrl_in <= '0;
    void'($urandom(32'hbfa8));
    load_steps();
    repeat (10) @(posedge sys_clk);
    rst_n <= 1'b1;
    if (file_ok) begin
      run_steps();
    end else begin
      $display("Stimulus file missing or unreadable, nothing was run");
    end
    assert_fails = u_roach_infrastructure.u_seq.u_assert.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, assert_fails);
    if (file_ok && errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog, armed once the hold total is known
  initial begin
    wait (cycle_budget > 0);
    #((cycle_budget + 200) * 20);
    $display("Timeout: stimulus did not finish within %0d cycles", cycle_budget + 200);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- sim/infra_stimulus.txt
# test lock idelay_rst hold | sys_clk_lock domain_rst_n(hex) idelay_rdy op_power_on_rst loss_count
# hold 0 asks for a random glitch length of 4 to 15 cycles
1 0 0 5  0 0 0 1 0
2 1 0 2  0 0 0 1 0
2 1 0 1  1 0 0 1 0
2 1 0 15 1 0 0 1 0
2 1 0 1  1 1 0 1 0
2 1 0 3  1 1 0 1 0
2 1 0 1  1 3 0 1 0
2 1 0 4  1 7 0 1 0
2 1 0 3  1 7 0 1 0
2 1 0 1  1 f 0 1 0
2 1 0 11 1 f 0 1 0
2 1 0 1  1 f 1 0 0
3 1 1 3  1 f 1 0 0
3 1 1 1  1 f 0 0 0
3 1 0 11 1 f 0 0 0
3 1 0 1  1 f 1 0 0
4 0 0 2  1 f 1 0 0
4 0 0 1  0 f 1 0 0
4 0 0 1  0 0 0 1 1
4 1 0 18 1 0 0 1 1
4 1 0 1  1 1 0 1 1
4 1 0 12 1 f 0 1 1
4 1 0 11 1 f 0 1 1
4 1 0 1  1 f 1 0 1
5 0 0 6  0 0 0 1 2
5 1 0 8  1 0 0 1 2
5 0 0 0  0 0 0 1 2
5 1 0 18 1 0 0 1 2
5 1 0 1  1 1 0 1 2
6 0 0 0  0 0 0 1 3
6 1 0 20 1 1 0 1 3
6 0 0 0  0 0 0 1 4
6 1 0 20 1 1 0 1 4
6 0 0 0  0 0 0 1 5
6 1 0 20 1 1 0 1 5
6 0 0 0  0 0 0 1 6
6 1 0 20 1 1 0 1 6
6 0 0 0  0 0 0 1 7
6 1 0 20 1 1 0 1 7
6 0 0 0  0 0 0 1 8
6 1 0 20 1 1 0 1 8
6 0 0 0  0 0 0 1 9
6 1 0 20 1 1 0 1 9
6 0 0 0  0 0 0 1 a
6 1 0 20 1 1 0 1 a
6 0 0 0  0 0 0 1 b
6 1 0 20 1 1 0 1 b
6 0 0 0  0 0 0 1 c
6 1 0 20 1 1 0 1 c
6 0 0 0  0 0 0 1 d
6 1 0 20 1 1 0 1 d
6 0 0 0  0 0 0 1 e
6 1 0 20 1 1 0 1 e
6 0 0 0  0 0 0 1 f
6 1 0 20 1 1 0 1 f
6 0 0 0  0 0 0 1 f

//--- build.f
rtl/infra_pkg.sv
rtl/infra_sync.sv
rtl/infra_timer.sv
rtl/infra_domain_rst.sv
rtl/infra_reset_seq.sv
rtl/roach_infrastructure.sv
sim/infra_assert.sv
sim/tb_roach_infrastructure.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_roach_infrastructure
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
OBJ_DIR   := obj_dir
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
